// File: verilog/tilemap_pkg.sv
`default_nettype none

package tilemap_pkg;

    typedef logic [23:0] vram_addr_t;   // video ram word address
    typedef logic [15:0] vram_word_t;   // tile code or attribute
    typedef logic [21:0] rom_addr_t;    // tile rom word address
    typedef logic [31:0] rom_word_t;    // 4 planes x 8 pixels
    typedef logic [8:0]  buf_addr_t;    // line buffer address
    typedef logic [7:0]  pixel_t;       // {palette, colour}
    typedef logic [15:0] scroll_t;      // scroll or base register

    localparam int line_width = 384;    // visible pixels per line

    // line controller states
    typedef enum logic [2:0] {
        idle,
        map_code,
        map_attr,
        rom_req,
        burst,
        line_done
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/tile_line_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tile_line_ctrl #(
    parameter int tile_size = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  tilemap_pkg::scroll_t hpos,
    input  logic                 start,
    output logic                 done,
    input  logic                 vram_ok,
    input  logic                 rom_ok,
    output logic                 vram_cs,
    output logic                 rom_cs,
    output logic                 line_init,
    output logic                 code_take,
    output logic                 attr_take,
    output logic                 tile_step,
    output logic                 word_load,
    output logic [1:0]           word_idx,
    input  logic                 burst_end
);
    import tilemap_pkg::*;

    localparam int words = tile_size / 8;   // rom words per tile row

    ctrl_state_t state;
    ctrl_state_t state_nx;
    logic [9:0]  px_cnt;      // pixels handed to the decoder
    logic [9:0]  end_cnt;
    logic [4:0]  fine;
    logic        draining;    // decoder still shifting out a word
    logic        dec_free;
    logic        last_word;
    logic        last_tile;

    assign fine      = hpos[4:0] & 5'(tile_size - 1);
    assign end_cnt   = 10'(line_width) + 10'(fine);
    assign last_word = (word_idx == 2'(words - 1));
    assign last_tile = (px_cnt + 10'd8 >= end_cnt);   // count after this word

    // a new word may only land on the last pixel of the previous one
    assign dec_free = !draining || burst_end;

    assign vram_cs = (state == map_code) || (state == map_attr);
    assign rom_cs  = (state == rom_req) && dec_free;
    assign done    = (state == line_done);

    always_comb begin
        state_nx  = state;
        line_init = 1'b0;
        code_take = 1'b0;
        attr_take = 1'b0;
        tile_step = 1'b0;
        word_load = 1'b0;
        case (state)
            idle: begin
                if (start) begin
                    line_init = 1'b1;
                    state_nx  = map_code;
                end
            end
            map_code: begin
                if (vram_ok) begin
                    code_take = 1'b1;
                    state_nx  = map_attr;
                end
            end
            map_attr: begin
                if (vram_ok) begin
                    attr_take = 1'b1;
                    state_nx  = rom_req;
                end
            end
            rom_req: begin
                if (rom_ok && dec_free) begin
                    word_load = 1'b1;
                    if (last_word) begin
                        tile_step = 1'b1;   // map reads overlap the burst
                        state_nx  = last_tile ? burst : map_code;
                    end
                end
            end
            burst: begin
                if (burst_end) begin
                    state_nx = line_done;
                end
            end
            line_done: begin
                if (!start) begin
                    state_nx = idle;
                end
            end
            default: begin
                state_nx = idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            word_idx <= 2'd0;
            px_cnt   <= 10'd0;
            draining <= 1'b0;
        end else begin
            state <= state_nx;
            if (line_init) begin
                word_idx <= 2'd0;
                px_cnt   <= 10'd0;
            end
            if (word_load) begin
                px_cnt   <= px_cnt + 10'd8;
                word_idx <= last_word ? 2'd0 : word_idx + 2'd1;
            end
            if (word_load) begin
                draining <= 1'b1;
            end else if (burst_end) begin
                draining <= 1'b0;
            end
        end
    end

    // memory ok only ever answers a request that is still up
    a_ok_with_cs: assert property (@(posedge clk) disable iff (rst)
        (!vram_ok || vram_cs) && (!rom_ok || rom_cs));

    // no read may be pending once the line is reported done
    a_done_quiet: assert property (@(posedge clk) disable iff (rst)
        done |-> !vram_cs && !rom_cs && !burst_end);

endmodule

`default_nettype wire

// File: verilog/tile_map_addr.sv
`timescale 1ns/1ps
`default_nettype none

module tile_map_addr #(
    parameter int tile_size = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [8:0]              v,
    input  tilemap_pkg::scroll_t    vram_base,
    input  tilemap_pkg::scroll_t    hpos,
    input  tilemap_pkg::scroll_t    vpos,
    input  logic                    line_init,
    input  logic                    code_take,
    input  logic                    attr_take,
    input  logic                    tile_step,
    input  tilemap_pkg::vram_word_t vram_data,
    output tilemap_pkg::vram_addr_t vram_addr,
    output tilemap_pkg::vram_word_t code,
    output tilemap_pkg::vram_word_t attr,
    output logic [4:0]              row
);
    import tilemap_pkg::*;

    localparam int sh = $clog2(tile_size);

    scroll_t     vn;
    scroll_t     hn;           // tile aligned column position
    scroll_t     base_q;
    logic        attr_phase;   // second word of the pair
    logic [5:0]  trow;
    logic [5:0]  tcol;
    logic [11:0] scan;

    assign trow = 6'(vn >> sh);
    assign tcol = 6'(hn >> sh);
    assign row  = vn[4:0] & 5'(tile_size - 1);

    always_comb begin
        case (tile_size)
            8:       scan = {trow[5],   tcol, trow[4:0]};
            16:      scan = {trow[5:4], tcol, trow[3:0]};
            default: scan = {trow[5:3], tcol, trow[2:0]};
        endcase
    end

    assign vram_addr = vram_addr_t'({base_q, 8'd0}) + vram_addr_t'({scan, attr_phase});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attr_phase <= 1'b0;
        end else if (code_take) begin
            attr_phase <= 1'b1;
        end else if (attr_take || line_init) begin
            attr_phase <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (line_init) begin
            vn     <= vpos + scroll_t'(v);
            hn     <= hpos & ~scroll_t'(tile_size - 1);
            base_q <= vram_base;
        end else if (tile_step) begin
            hn <= hn + scroll_t'(tile_size);
        end
        if (code_take) begin
            code <= vram_data;
        end
        if (attr_take) begin
            attr <= vram_data;
        end
    end

    // attribute address stays put until its word is taken
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        attr_phase && !attr_take |=> $stable(vram_addr));

endmodule

`default_nettype wire

// File: verilog/tile_rom_addr.sv
`timescale 1ns/1ps
`default_nettype none

module tile_rom_addr #(
    parameter int tile_size = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  tilemap_pkg::vram_word_t code,
    input  logic [4:0]              row,
    input  logic [1:0]              word_idx,
    output tilemap_pkg::rom_addr_t  rom_addr
);
    import tilemap_pkg::*;

    rom_addr_t addr_nx;

    // wider tiles split a row over 2 or 4 words
    always_comb begin
        case (tile_size)
            8:       addr_nx = rom_addr_t'({code, row[2:0]});
            16:      addr_nx = rom_addr_t'({code, row[3:0], word_idx[0]});
            default: addr_nx = rom_addr_t'({code, row, word_idx});   // top code bit lost
        endcase
    end

    always_ff @(posedge clk) begin
        rom_addr <= addr_nx;
    end

    // controller never asks past the last word of a tile row
    a_word_range: assert property (@(posedge clk) disable iff (rst)
        32'(word_idx) < tile_size / 8);

endmodule

`default_nettype wire

// File: verilog/planar_pixel_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module planar_pixel_unpack #(
    parameter int tile_size = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  tilemap_pkg::scroll_t    hpos,
    input  logic                    line_init,
    input  logic                    word_load,
    input  tilemap_pkg::rom_word_t  rom_data,
    input  tilemap_pkg::vram_word_t attr,
    output tilemap_pkg::buf_addr_t  buf_addr,
    output tilemap_pkg::pixel_t     buf_data,
    output logic                    buf_wr,
    output logic                    burst_end
);
    import tilemap_pkg::*;

    rom_word_t  sh_word;
    logic [3:0] pal;       // palette held for the whole word
    logic [2:0] left;      // pixels after the one being written
    logic [4:0] fine;

    // one bit per plane, plane 3 on top
    function automatic logic [3:0] colour(input rom_word_t w);
        return {w[24], w[16], w[8], w[0]};
    endfunction

    assign fine      = hpos[4:0] & 5'(tile_size - 1);
    assign burst_end = buf_wr && (left == 3'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_wr   <= 1'b0;
            left     <= 3'd0;
            buf_addr <= buf_addr_t'(0);
        end else begin
            if (line_init) begin
                buf_addr <= buf_addr_t'(0) - buf_addr_t'(fine);   // wraps off screen
            end else if (buf_wr) begin
                buf_addr <= buf_addr + buf_addr_t'(1);
            end
            if (word_load) begin
                buf_wr <= 1'b1;
                left   <= 3'd7;
            end else if (buf_wr && left != 3'd0) begin
                left <= left - 3'd1;
            end else begin
                buf_wr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_load) begin
            pal      <= attr[3:0];
            buf_data <= {attr[3:0], colour(rom_data)};
            sh_word  <= rom_data >> 1;
        end else if (buf_wr && left != 3'd0) begin
            buf_data <= {pal, colour(sh_word)};
            sh_word  <= sh_word >> 1;
        end
    end

    // a word only arrives once the previous one is on its last pixel
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        word_load |-> left == 3'd0);

endmodule

`default_nettype wire

// File: verilog/tile_line_render.sv
`timescale 1ns/1ps
`default_nettype none

module tile_line_render #(
    parameter int tile_size = 16   // 8, 16 or 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [8:0]              v,
    input  tilemap_pkg::scroll_t    vram_base,
    input  tilemap_pkg::scroll_t    hpos,
    input  tilemap_pkg::scroll_t    vpos,
    input  logic                    start,
    output logic                    done,
    output logic                    vram_cs,
    output tilemap_pkg::vram_addr_t vram_addr,
    input  tilemap_pkg::vram_word_t vram_data,
    input  logic                    vram_ok,
    output logic                    rom_cs,
    output tilemap_pkg::rom_addr_t  rom_addr,
    input  tilemap_pkg::rom_word_t  rom_data,
    input  logic                    rom_ok,
    output tilemap_pkg::buf_addr_t  buf_addr,
    output tilemap_pkg::pixel_t     buf_data,
    output logic                    buf_wr
);
    import tilemap_pkg::*;

    logic       line_init;
    logic       code_take;
    logic       attr_take;
    logic       tile_step;
    logic       word_load;
    logic       burst_end;
    logic [1:0] word_idx;
    logic [4:0] row;
    vram_word_t code;
    vram_word_t attr;

    tile_line_ctrl #(.tile_size(tile_size)) i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .hpos      (hpos),
        .start     (start),
        .done      (done),
        .vram_ok   (vram_ok),
        .rom_ok    (rom_ok),
        .vram_cs   (vram_cs),
        .rom_cs    (rom_cs),
        .line_init (line_init),
        .code_take (code_take),
        .attr_take (attr_take),
        .tile_step (tile_step),
        .word_load (word_load),
        .word_idx  (word_idx),
        .burst_end (burst_end)
    );

    tile_map_addr #(.tile_size(tile_size)) i_map (
        .clk       (clk),
        .rst       (rst),
        .v         (v),
        .vram_base (vram_base),
        .hpos      (hpos),
        .vpos      (vpos),
        .line_init (line_init),
        .code_take (code_take),
        .attr_take (attr_take),
        .tile_step (tile_step),
        .vram_data (vram_data),
        .vram_addr (vram_addr),
        .code      (code),
        .attr      (attr),
        .row       (row)
    );

    tile_rom_addr #(.tile_size(tile_size)) i_rom_addr (
        .clk      (clk),
        .rst      (rst),
        .code     (code),
        .row      (row),
        .word_idx (word_idx),
        .rom_addr (rom_addr)
    );

    planar_pixel_unpack #(.tile_size(tile_size)) i_unpack (
        .clk       (clk),
        .rst       (rst),
        .hpos      (hpos),
        .line_init (line_init),
        .word_load (word_load),
        .rom_data  (rom_data),
        .attr      (attr),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr),
        .burst_end (burst_end)
    );

endmodule

`default_nettype wire

// File: tb/tile_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tile_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [2:0]              vram_lat,
    input  logic [2:0]              rom_lat,
    input  logic                    vram_cs,
    input  tilemap_pkg::vram_addr_t vram_addr,
    output tilemap_pkg::vram_word_t vram_data,
    output logic                    vram_ok,
    input  logic                    rom_cs,
    input  tilemap_pkg::rom_addr_t  rom_addr,
    output tilemap_pkg::rom_word_t  rom_data,
    output logic                    rom_ok
);
    import tilemap_pkg::*;

    logic [2:0] vram_wait;   // cycles left before ok
    logic [2:0] rom_wait;

    // map words serve as code or attribute alike
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vram_ok   <= 1'b0;
            vram_wait <= 3'd0;
            vram_data <= '0;
        end else if (vram_ok) begin
            vram_ok   <= 1'b0;
            vram_wait <= vram_lat;   // latency of the next read
        end else if (vram_cs) begin
            if (vram_wait == 3'd0) begin
                vram_ok   <= 1'b1;
                vram_data <= vram_addr[15:0] ^ 16'h5a3c;
            end else begin
                vram_wait <= vram_wait - 3'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_wait <= 3'd0;
            rom_data <= '0;
        end else if (rom_ok) begin
            rom_ok   <= 1'b0;
            rom_wait <= rom_lat;
        end else if (rom_cs) begin
            if (rom_wait == 3'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word_t'(rom_addr) * 32'h9e3779b1;   // hashed planar word
            end else begin
                rom_wait <= rom_wait - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_tile_line_render.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_line_render;
    import tilemap_pkg::*;

    localparam int lines   = 20;
    localparam int timeout = 4000;   // cycles allowed per wait

    logic        clk;
    logic        rst;
    logic [8:0]  v;
    scroll_t     vram_base;
    scroll_t     hpos;
    scroll_t     vpos;
    logic        start;
    logic        done;
    logic        vram_cs;
    vram_addr_t  vram_addr;
    vram_word_t  vram_data;
    logic        vram_ok;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    rom_word_t   rom_data;
    logic        rom_ok;
    buf_addr_t   buf_addr;
    pixel_t      buf_data;
    logic        buf_wr;
    logic [2:0]  vram_lat;
    logic [2:0]  rom_lat;
    logic [31:0] lfsr;
    pixel_t      expected [0:511];
    int          written_line [0:511];   // last line that wrote each address
    int          cur_line;
    int          pixel_errors;
    int          other_errors;
    logic        timed_out;

    tile_line_render #(.tile_size(16)) i_dut (.*);
    tile_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'hb4bcd35c : s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = 32'd0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // pixel at world position wx, wy for 16 pixel tiles
    function automatic pixel_t ref_pixel(input scroll_t base, input scroll_t wx,
                                         input scroll_t wy);
        logic [11:0] scan;
        vram_addr_t  map_addr;
        vram_word_t  code;
        vram_word_t  attr;
        rom_word_t   gfx;
        scan     = {wy[9:8], wx[9:4], wy[7:4]};
        map_addr = {base, 8'd0} + {11'd0, scan, 1'b0};
        code     = map_addr[15:0] ^ 16'h5a3c;
        attr     = (map_addr[15:0] + 16'd1) ^ 16'h5a3c;
        gfx      = {11'd0, code, wy[3:0], wx[3]} * 32'h9e3779b1;
        return {attr[3:0], gfx[{2'b11, wx[2:0]}], gfx[{2'b10, wx[2:0]}],
                gfx[{2'b01, wx[2:0]}], gfx[{2'b00, wx[2:0]}]};
    endfunction

    // one clock, with fresh memory latencies
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        take_bits(6, r);
        vram_lat <= r[2:0];
        rom_lat  <= r[5:3];
    endtask

    task automatic wait_done(input logic level);
        int n;
        n = 0;
        while (done !== level && n < timeout) begin
            next_cycle();
            n++;
        end
        if (done !== level) begin
            $display("timed out waiting for done to go %0d", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_line(input int line);
        logic [31:0] r;
        scroll_t     h;
        scroll_t     vp;
        scroll_t     base;
        logic [8:0]  vl;
        take_bits(12, r);
        h = {r[11:0], 4'(line)};   // walks through every fine offset
        take_bits(16, r);
        vp = r[15:0];
        take_bits(16, r);
        base = r[15:0];
        take_bits(8, r);
        vl = {1'b0, r[7:0]};
        cur_line = line + 1;
        for (int x = 0; x < line_width; x++) begin
            expected[x] = ref_pixel(base, h + scroll_t'(x), vp + scroll_t'(vl));
        end
        next_cycle();
        hpos      <= h;
        vpos      <= vp;
        v         <= vl;
        vram_base <= base;
        start     <= 1'b1;
        wait_done(1'b1);
        if (!timed_out) begin
            take_bits(3, r);
            repeat (int'(r[2:0]) + 1) next_cycle();   // keep start held past done
            for (int x = 0; x < line_width; x++) begin
                assert (written_line[x] == cur_line) else begin
                    other_errors++;
                    $display("address %0d was not written before done", x);
                end
            end
            start <= 1'b0;
            wait_done(1'b0);
        end
    endtask

    // visible writes against the shadow line
    always @(posedge clk) begin
        if (!rst && buf_wr && buf_addr < buf_addr_t'(line_width)) begin
            written_line[buf_addr] = cur_line;
            assert (buf_data == expected[buf_addr]) else begin
                pixel_errors++;
                $display("Error: buf_data = %h, expected %h at buf_addr %h",
                    buf_data, expected[buf_addr], buf_addr);
            end
        end
    end

    a_vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_cs && !vram_ok |=> vram_cs && $stable(vram_addr)) else begin
        other_errors++;
        $display("video ram request changed before its ok");
    end

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)) else begin
        other_errors++;
        $display("rom request changed before its ok");
    end

    a_done_quiet: assert property (@(posedge clk) disable iff (rst)
        done |-> !buf_wr) else begin
        other_errors++;
        $display("line buffer written while done is high");
    end

    a_done_held: assert property (@(posedge clk) disable iff (rst)
        done && start |=> done) else begin
        other_errors++;
        $display("done fell while start was still held");
    end

    a_done_drop: assert property (@(posedge clk) disable iff (rst)
        done && !start |=> !done) else begin
        other_errors++;
        $display("done stayed high after start dropped");
    end

    initial begin
        lfsr         = 32'h0d873d50;
        pixel_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        cur_line     = 0;
        rst          = 1'b1;
        start        = 1'b0;
        v            = 9'd0;
        vram_base    = 16'd0;
        hpos         = 16'd0;
        vpos         = 16'd0;
        vram_lat     = 3'd0;
        rom_lat      = 3'd0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        next_cycle();
        assert (!done && !vram_cs && !rom_cs && !buf_wr) else begin
            other_errors++;
            $display("outputs were not idle right after reset");
        end
        for (int i = 0; i < lines && !timed_out; i++) begin
            run_line(i);
        end
        $display("errors: %0d pixel, %0d other", pixel_errors, other_errors);
        if (timed_out || pixel_errors + other_errors > 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/tilemap_pkg.sv
verilog/tile_line_ctrl.sv
verilog/tile_map_addr.sv
verilog/tile_rom_addr.sv
verilog/planar_pixel_unpack.sv
verilog/tile_line_render.sv
tb/tile_mem_model.sv
tb/tb_tile_line_render.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = tb_tile_line_render
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
